// ==== logic/mem_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Memory unit widths, operation and exception encodings, queue entry
////////////////////////////////////////////////////////////////////////////
package mem_pkg;

    localparam int XLEN       = 64;
    localparam int VADDR_BITS = 39;   // Bits above this must all match
    localparam int GL_INDEX_W = 6;
    localparam int REG_ADDR_W = 5;
    localparam int LSQ_DEPTH  = 4;
    localparam int LSQ_PTR_W  = $clog2(LSQ_DEPTH);

    // Scalar memory operations
    typedef enum logic [3:0] {
        LD,
        LW,
        LWU,
        LH,
        LHU,
        LB,
        LBU,
        SD,
        SW,
        SH,
        SB
    } mem_op_t;

    // RISC-V cause codes raised by the memory unit
    typedef enum logic [3:0] {
        LD_ADDR_MISALIGNED = 4'd4,
        LD_ACCESS_FAULT    = 4'd5,
        ST_ADDR_MISALIGNED = 4'd6,
        ST_ACCESS_FAULT    = 4'd7,
        LD_PAGE_FAULT      = 4'd13,
        ST_PAGE_FAULT      = 4'd15
    } xcpt_cause_t;

    // One load/store queue slot
    typedef struct packed {
        logic                  valid;
        mem_op_t               op;
        logic [REG_ADDR_W-1:0] rd;
        logic [GL_INDEX_W-1:0] gl_index;
        logic [XLEN-1:0]       base;     // First operand
        logic [XLEN-1:0]       imm;
        logic [XLEN-1:0]       wdata;    // Store data from the second operand
    } mem_entry_t;

    function automatic logic is_store(input mem_op_t op);
        return op inside {SD, SW, SH, SB};
    endfunction

endpackage

// ==== logic/load_store_queue.sv ====
////////////////////////////////////////////////////////////////////////////
// Load/store queue with head, issue and write pointers
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module load_store_queue import mem_pkg::*; (
    input  logic       clk_i,
    input  logic       rstn_i,
    input  logic       flush_i,
    input  logic       push_i,
    input  mem_entry_t push_entry_i,
    input  logic       issue_read_i,
    input  logic       advance_head_i,
    input  logic       rewind_i,
    output mem_entry_t issue_entry_o,
    output logic       full_o,
    output logic       empty_o
);

    // Pointers carry one wrap bit above the slot index
    logic [LSQ_PTR_W:0] wr_q;
    logic [LSQ_PTR_W:0] head_q;     // Oldest unfinished entry
    logic [LSQ_PTR_W:0] issue_q;    // Next entry to send
    logic               push_ok;

    mem_entry_t mem_q [LSQ_DEPTH];

    assign full_o  = (wr_q[LSQ_PTR_W] != head_q[LSQ_PTR_W]) &&
                     (wr_q[LSQ_PTR_W-1:0] == head_q[LSQ_PTR_W-1:0]);
    assign empty_o = (wr_q == head_q);
    assign push_ok = push_i & ~full_o;

    always_ff @(posedge clk_i) begin
        if (push_ok) begin
            mem_q[wr_q[LSQ_PTR_W-1:0]] <= push_entry_i;
        end
    end

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            wr_q    <= '0;
            head_q  <= '0;
            issue_q <= '0;
        end else if (flush_i) begin
            wr_q    <= '0;
            head_q  <= '0;
            issue_q <= '0;
        end else begin
            if (push_ok) begin
                wr_q <= wr_q + 1'b1;
            end
            if (advance_head_i) begin
                head_q <= head_q + 1'b1;
            end
            if (rewind_i) begin
                issue_q <= head_q;          // Replay from the oldest entry
            end else if (issue_read_i) begin
                issue_q <= issue_q + 1'b1;
            end
        end
    end

    always_comb begin
        issue_entry_o       = mem_q[issue_q[LSQ_PTR_W-1:0]];
        issue_entry_o.valid = (issue_q != wr_q);   // Something left to send
    end

endmodule

// ==== logic/mem_issue_ctrl.sv ====
////////////////////////////////////////////////////////////////////////////
// Issue FSM, cache request drive and store commit gating
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module mem_issue_ctrl import mem_pkg::*; (
    input  logic            clk_i,
    input  logic            rstn_i,
    input  logic            kill_i,
    input  mem_entry_t      issue_entry_i,
    input  logic            issue_empty_i,
    input  logic            dc_ready_i,
    input  logic            commit_store_i,
    input  logic            store_done_i,
    input  logic            rewind_i,
    output logic            issue_read_o,
    output logic            dc_req_valid_o,
    output mem_op_t         dc_req_op_o,
    output logic [XLEN-1:0] dc_req_addr_o,
    output logic            s1_valid_o,
    output mem_entry_t      s1_entry_o,
    output logic            commit_stall_o
);

    typedef enum logic [1:0] {
        RESET,
        READ_HEAD,
        WAIT_READY,
        WAIT_COMMIT
    } state_t;

    state_t     state_q;
    state_t     state_d;
    mem_entry_t held_q;         // Entry read from the queue and not yet sent
    mem_entry_t cur_entry;
    logic       cur_store;
    logic       can_go;
    logic       fire;
    logic       store_inflight_q;

    // Queue head in READ_HEAD and the held copy while waiting
    always_comb begin
        if (state_q == READ_HEAD) begin
            cur_entry       = issue_entry_i;
            cur_entry.valid = issue_entry_i.valid & ~issue_empty_i;
        end else begin
            cur_entry       = held_q;
            cur_entry.valid = (state_q != RESET);
        end
    end

    assign cur_store    = is_store(cur_entry.op);
    assign can_go       = ~cur_store | (commit_store_i & ~store_inflight_q);
    assign fire         = cur_entry.valid & dc_ready_i & can_go & ~kill_i & ~rewind_i;
    assign issue_read_o = (state_q == READ_HEAD) & cur_entry.valid;

    always_comb begin
        case (state_q)
            RESET:   state_d = READ_HEAD;
            default: begin
                if (!cur_entry.valid || fire) begin
                    state_d = READ_HEAD;
                end else if (can_go) begin
                    state_d = WAIT_READY;   // Only the cache is holding us
                end else begin
                    state_d = WAIT_COMMIT;
                end
            end
        endcase
    end

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= RESET;
        end else if (kill_i || rewind_i) begin
            state_q <= READ_HEAD;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue_read_o) begin
            held_q <= issue_entry_i;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Store tracking with one store in the pipeline at a time
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            store_inflight_q <= 1'b0;
        end else if (kill_i || rewind_i) begin
            store_inflight_q <= 1'b0;   // Store will be replayed or dropped
        end else if (fire && cur_store) begin
            store_inflight_q <= 1'b1;
        end else if (store_done_i) begin
            store_inflight_q <= 1'b0;
        end
    end

    assign commit_stall_o = store_inflight_q | (fire & cur_store);

    assign dc_req_valid_o = fire;
    assign dc_req_op_o    = cur_entry.op;
    assign dc_req_addr_o  = cur_entry.base + cur_entry.imm;   // Effective address
    assign s1_valid_o     = fire;
    assign s1_entry_o     = cur_entry;

endmodule

// ==== logic/mem_resp_pipe.sv ====
////////////////////////////////////////////////////////////////////////////
// Request tracking stages, response decision and writeback drive
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module mem_resp_pipe import mem_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  kill_i,
    input  logic                  s1_valid_i,
    input  mem_entry_t            s1_entry_i,
    input  logic [XLEN-1:0]       s1_addr_i,
    input  logic                  dc_resp_valid_i,
    input  logic                  dc_resp_nack_i,
    input  logic [XLEN-1:0]       dc_resp_data_i,
    input  logic                  dc_resp_ma_i,
    input  logic                  dc_resp_pf_i,
    input  logic                  xcpt_valid_i,
    input  xcpt_cause_t           xcpt_cause_i,
    output logic [XLEN-1:0]       dc_req_wdata_o,
    output mem_entry_t            s2_entry_o,
    output logic [XLEN-1:0]       s2_addr_o,
    output logic                  advance_head_o,
    output logic                  rewind_o,
    output logic                  store_done_o,
    output logic                  wb_valid_o,
    output logic [REG_ADDR_W-1:0] wb_rd_o,
    output logic [GL_INDEX_W-1:0] wb_gl_index_o,
    output logic [XLEN-1:0]       wb_data_o,
    output logic                  wb_xcpt_valid_o,
    output xcpt_cause_t           wb_xcpt_cause_o,
    output logic [XLEN-1:0]       wb_xcpt_origin_o,
    output logic                  commit_xcpt_valid_o,
    output xcpt_cause_t           commit_xcpt_cause_o,
    output logic [XLEN-1:0]       commit_xcpt_origin_o
);

    logic            s1_valid_q;
    logic            s2_valid_q;
    mem_entry_t      s1_entry_q;
    mem_entry_t      s2_entry_q;
    logic [XLEN-1:0] s1_addr_q;
    logic [XLEN-1:0] s2_addr_q;
    logic            s2_store;
    logic            complete;

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else if (kill_i || rewind_o) begin
            s1_valid_q <= 1'b0;     // Younger requests are replayed
            s2_valid_q <= 1'b0;
        end else begin
            s1_valid_q <= s1_valid_i;
            s2_valid_q <= s1_valid_q;
        end
    end

    always_ff @(posedge clk_i) begin
        s1_entry_q <= s1_entry_i;
        s1_addr_q  <= s1_addr_i;
        s2_entry_q <= s1_entry_q;
        s2_addr_q  <= s1_addr_q;
    end

    assign dc_req_wdata_o = s1_entry_q.wdata;   // Store data follows by one cycle

    always_comb begin
        s2_entry_o       = s2_entry_q;
        s2_entry_o.valid = s2_valid_q;
    end
    assign s2_addr_o = s2_addr_q;
    assign s2_store  = is_store(s2_entry_q.op);

    // Nack first, then exception, then a plain response
    assign rewind_o = s2_valid_q & dc_resp_nack_i;
    assign complete = s2_valid_q & ~dc_resp_nack_i & ~kill_i &
                      (xcpt_valid_i | dc_resp_valid_i);

    assign advance_head_o = complete;
    assign store_done_o   = complete & s2_store;

    // Loads, faulting or not, retire through writeback
    assign wb_valid_o       = complete & ~s2_store;
    assign wb_rd_o          = s2_entry_q.rd;
    assign wb_gl_index_o    = s2_entry_q.gl_index;
    assign wb_data_o        = dc_resp_data_i;
    assign wb_xcpt_valid_o  = wb_valid_o & xcpt_valid_i;
    assign wb_xcpt_cause_o  = xcpt_cause_i;
    assign wb_xcpt_origin_o = s2_addr_q;

    // Store faults are reported to commit
    assign commit_xcpt_valid_o  = store_done_o & xcpt_valid_i;
    assign commit_xcpt_cause_o  = xcpt_cause_i;
    assign commit_xcpt_origin_o = s2_addr_q;

endmodule

// ==== logic/mem_xcpt_check.sv ====
////////////////////////////////////////////////////////////////////////////
// Exception classification for the stage-2 instruction
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module mem_xcpt_check import mem_pkg::*; (
    input  mem_entry_t      s2_entry_i,
    input  logic [XLEN-1:0] s2_addr_i,
    input  logic            ma_i,
    input  logic            pf_i,
    output logic            xcpt_valid_o,
    output xcpt_cause_t     xcpt_cause_o
);

    logic st;
    logic canonical;

    assign st = is_store(s2_entry_i.op);

    // Upper address bits must all be ones or all zeros
    assign canonical = (&s2_addr_i[XLEN-1:VADDR_BITS]) | ~(|s2_addr_i[XLEN-1:VADDR_BITS]);

    assign xcpt_valid_o = s2_entry_i.valid & (ma_i | pf_i | ~canonical);

    always_comb begin
        if (ma_i) begin
            xcpt_cause_o = st ? ST_ADDR_MISALIGNED : LD_ADDR_MISALIGNED;
        end else if (pf_i) begin
            xcpt_cause_o = st ? ST_PAGE_FAULT : LD_PAGE_FAULT;
        end else if (!canonical) begin
            xcpt_cause_o = st ? ST_ACCESS_FAULT : LD_ACCESS_FAULT;
        end else begin
            xcpt_cause_o = LD_ADDR_MISALIGNED;  // Unused while valid is low
        end
    end

endmodule

// ==== logic/mem_unit.sv ====
////////////////////////////////////////////////////////////////////////////
// Memory unit top level with queue, issue control, response pipe and
// exception check
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module mem_unit import mem_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  kill_i,
    input  logic                  instr_valid_i,
    input  mem_op_t               instr_op_i,
    input  logic [REG_ADDR_W-1:0] instr_rd_i,
    input  logic [GL_INDEX_W-1:0] instr_gl_index_i,
    input  logic [XLEN-1:0]       instr_base_i,
    input  logic [XLEN-1:0]       instr_imm_i,
    input  logic [XLEN-1:0]       instr_wdata_i,
    input  logic                  dc_ready_i,
    input  logic                  dc_resp_valid_i,
    input  logic                  dc_resp_nack_i,
    input  logic [XLEN-1:0]       dc_resp_data_i,
    input  logic                  dc_resp_ma_i,
    input  logic                  dc_resp_pf_i,
    input  logic                  commit_store_i,
    output logic                  dc_req_valid_o,
    output mem_op_t               dc_req_op_o,
    output logic [XLEN-1:0]       dc_req_addr_o,
    output logic [XLEN-1:0]       dc_req_wdata_o,
    output logic                  wb_valid_o,
    output logic [REG_ADDR_W-1:0] wb_rd_o,
    output logic [GL_INDEX_W-1:0] wb_gl_index_o,
    output logic [XLEN-1:0]       wb_data_o,
    output logic                  wb_xcpt_valid_o,
    output xcpt_cause_t           wb_xcpt_cause_o,
    output logic [XLEN-1:0]       wb_xcpt_origin_o,
    output logic                  commit_xcpt_valid_o,
    output xcpt_cause_t           commit_xcpt_cause_o,
    output logic [XLEN-1:0]       commit_xcpt_origin_o,
    output logic                  commit_stall_o,
    output logic                  lock_o,
    output logic                  empty_o
);

    mem_entry_t      push_entry;
    mem_entry_t      issue_entry;
    mem_entry_t      s1_entry;
    mem_entry_t      s2_entry;
    logic [XLEN-1:0] s2_addr;
    logic            lsq_empty;
    logic            issue_read;
    logic            advance_head;
    logic            rewind;
    logic            store_done;
    logic            s1_valid;
    logic            xcpt_valid;
    xcpt_cause_t     xcpt_cause;

    assign push_entry = '{valid: instr_valid_i, op: instr_op_i, rd: instr_rd_i,
                          gl_index: instr_gl_index_i, base: instr_base_i,
                          imm: instr_imm_i, wdata: instr_wdata_i};

    assign empty_o = lsq_empty & ~dc_req_valid_o;

    load_store_queue i_lsq (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .flush_i        (kill_i),
        .push_i         (instr_valid_i),
        .push_entry_i   (push_entry),
        .issue_read_i   (issue_read),
        .advance_head_i (advance_head),
        .rewind_i       (rewind),
        .issue_entry_o  (issue_entry),
        .full_o         (lock_o),
        .empty_o        (lsq_empty)
    );

    mem_issue_ctrl i_issue (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .kill_i         (kill_i),
        .issue_entry_i  (issue_entry),
        .issue_empty_i  (lsq_empty),
        .dc_ready_i     (dc_ready_i),
        .commit_store_i (commit_store_i),
        .store_done_i   (store_done),
        .rewind_i       (rewind),
        .issue_read_o   (issue_read),
        .dc_req_valid_o (dc_req_valid_o),
        .dc_req_op_o    (dc_req_op_o),
        .dc_req_addr_o  (dc_req_addr_o),
        .s1_valid_o     (s1_valid),
        .s1_entry_o     (s1_entry),
        .commit_stall_o (commit_stall_o)
    );

    mem_resp_pipe i_resp (
        .clk_i                (clk_i),
        .rstn_i               (rstn_i),
        .kill_i               (kill_i),
        .s1_valid_i           (s1_valid),
        .s1_entry_i           (s1_entry),
        .s1_addr_i            (dc_req_addr_o),
        .dc_resp_valid_i      (dc_resp_valid_i),
        .dc_resp_nack_i       (dc_resp_nack_i),
        .dc_resp_data_i       (dc_resp_data_i),
        .dc_resp_ma_i         (dc_resp_ma_i),
        .dc_resp_pf_i         (dc_resp_pf_i),
        .xcpt_valid_i         (xcpt_valid),
        .xcpt_cause_i         (xcpt_cause),
        .dc_req_wdata_o       (dc_req_wdata_o),
        .s2_entry_o           (s2_entry),
        .s2_addr_o            (s2_addr),
        .advance_head_o       (advance_head),
        .rewind_o             (rewind),
        .store_done_o         (store_done),
        .wb_valid_o           (wb_valid_o),
        .wb_rd_o              (wb_rd_o),
        .wb_gl_index_o        (wb_gl_index_o),
        .wb_data_o            (wb_data_o),
        .wb_xcpt_valid_o      (wb_xcpt_valid_o),
        .wb_xcpt_cause_o      (wb_xcpt_cause_o),
        .wb_xcpt_origin_o     (wb_xcpt_origin_o),
        .commit_xcpt_valid_o  (commit_xcpt_valid_o),
        .commit_xcpt_cause_o  (commit_xcpt_cause_o),
        .commit_xcpt_origin_o (commit_xcpt_origin_o)
    );

    mem_xcpt_check i_xcpt (
        .s2_entry_i   (s2_entry),
        .s2_addr_i    (s2_addr),
        .ma_i         (dc_resp_ma_i),
        .pf_i         (dc_resp_pf_i),
        .xcpt_valid_o (xcpt_valid),
        .xcpt_cause_o (xcpt_cause)
    );

endmodule

// ==== testbench/tb_clock_gen.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench clock (8 ns) and active-low reset for four cycles
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic rstn_o
);

    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;
    end

    initial begin
        rstn_o = 1'b0;
        repeat (4) @(posedge clk_o);
        @(negedge clk_o);
        rstn_o = 1'b1;      // Release away from the active edge
    end

endmodule

// ==== testbench/tb_mem_unit.sv ====
////////////////////////////////////////////////////////////////////////////
// Memory unit testbench with cache model, stimulus table, checks and watchdog
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_mem_unit import mem_pkg::*; ();

    localparam int NUM_ROWS = 13;
    localparam logic [1:0] ACT_OK   = 2'd0;
    localparam logic [1:0] ACT_NACK = 2'd1;   // Nack once and then ok
    localparam logic [1:0] ACT_MA   = 2'd2;
    localparam logic [1:0] ACT_PF   = 2'd3;

    logic clk_i, rstn_i, kill_i, instr_valid_i, dc_ready_i, commit_store_i;
    mem_op_t instr_op_i;
    logic [REG_ADDR_W-1:0] instr_rd_i;
    logic [GL_INDEX_W-1:0] instr_gl_index_i;
    logic [XLEN-1:0] instr_base_i, instr_imm_i, instr_wdata_i, dc_resp_data_i;
    logic dc_resp_valid_i, dc_resp_nack_i, dc_resp_ma_i, dc_resp_pf_i;
    logic dc_req_valid_o, wb_valid_o, wb_xcpt_valid_o, commit_xcpt_valid_o;
    logic commit_stall_o, lock_o, empty_o;
    mem_op_t dc_req_op_o;
    logic [XLEN-1:0] dc_req_addr_o, dc_req_wdata_o, wb_data_o;
    logic [XLEN-1:0] wb_xcpt_origin_o, commit_xcpt_origin_o;
    logic [REG_ADDR_W-1:0] wb_rd_o;
    logic [GL_INDEX_W-1:0] wb_gl_index_o;
    xcpt_cause_t wb_xcpt_cause_o, commit_xcpt_cause_o;

    // Stimulus table with one instruction per row
    mem_op_t               row_op    [NUM_ROWS];
    logic [XLEN-1:0]       row_base  [NUM_ROWS];
    logic [XLEN-1:0]       row_imm   [NUM_ROWS];
    logic [REG_ADDR_W-1:0] row_rd    [NUM_ROWS];
    logic [GL_INDEX_W-1:0] row_gl    [NUM_ROWS];
    logic [XLEN-1:0]       row_wdata [NUM_ROWS];
    logic [1:0]            row_act   [NUM_ROWS];
    logic [XLEN-1:0]       row_data  [NUM_ROWS];
    logic                  row_xv    [NUM_ROWS];
    xcpt_cause_t           row_cause [NUM_ROWS];
    logic                  row_nacked[NUM_ROWS];

    int     load_list[$];
    int     stx_list[$];     // Faulting stores in order
    int     load_pos, stx_pos, p1_idx, p2_idx, wd_idx, cs_wait;
    logic   nack_now, stall_pend, hold_ready, kill_phase;
    integer seed;

    tb_clock_gen i_clk (.clk_o(clk_i), .rstn_o(rstn_i));

    mem_unit i_dut (.*);

    task automatic report_error(input string msg);
        $display("FAIL at %0t ns: %s", $time, msg);
        $display("Test failures found");
        $fatal(1, "Check failed");
    endtask

    task automatic add_row(input int i, input mem_op_t op, input logic [XLEN-1:0] base,
                           input logic [XLEN-1:0] imm, input logic [REG_ADDR_W-1:0] rd,
                           input logic [GL_INDEX_W-1:0] gl, input logic [XLEN-1:0] wdata,
                           input logic [1:0] act, input logic [XLEN-1:0] data,
                           input logic xv, input xcpt_cause_t cause);
        row_op[i]     = op;
        row_base[i]   = base;
        row_imm[i]    = imm;
        row_rd[i]     = rd;
        row_gl[i]     = gl;
        row_wdata[i]  = wdata;
        row_act[i]    = act;
        row_data[i]   = data;
        row_xv[i]     = xv;
        row_cause[i]  = cause;
        row_nacked[i] = 1'b0;
    endtask

    function automatic logic op_writes_mem(input mem_op_t op);
        return (op == SD) || (op == SW) || (op == SH) || (op == SB);
    endfunction

    // Rows have distinct effective addresses so the address finds the row
    function automatic int find_row(input logic [XLEN-1:0] addr);
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (row_base[i] + row_imm[i] == addr) return i;
        end
        return -1;
    endfunction

    task automatic push_row(input int i);
        while (lock_o) @(negedge clk_i);
        instr_valid_i    = 1'b1;
        instr_op_i       = row_op[i];
        instr_rd_i       = row_rd[i];
        instr_gl_index_i = row_gl[i];
        instr_base_i     = row_base[i];
        instr_imm_i      = row_imm[i];
        instr_wdata_i    = row_wdata[i];
        @(negedge clk_i);
        instr_valid_i    = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Cache model with ready and commit drive on the falling edge
    ////////////////////////////////////////////////////////////////////////////
    always @(negedge clk_i) begin
        if (commit_stall_o) begin
            commit_store_i = 1'b0;
            cs_wait        = $unsigned($random(seed)) % 4;
        end else if (cs_wait == 0) begin
            commit_store_i = 1'b1;
        end else begin
            cs_wait = cs_wait - 1;
        end
        dc_resp_valid_i = 1'b0;
        dc_resp_nack_i  = 1'b0;
        dc_resp_ma_i    = 1'b0;
        dc_resp_pf_i    = 1'b0;
        dc_resp_data_i  = '0;
        nack_now        = 1'b0;
        if (p2_idx >= 0) begin
            if (row_act[p2_idx] == ACT_NACK && !row_nacked[p2_idx]) begin
                dc_resp_nack_i     = 1'b1;
                row_nacked[p2_idx] = 1'b1;
                nack_now           = 1'b1;
            end else begin
                dc_resp_valid_i = 1'b1;
                dc_resp_data_i  = row_data[p2_idx];
                dc_resp_ma_i    = (row_act[p2_idx] == ACT_MA);
                dc_resp_pf_i    = (row_act[p2_idx] == ACT_PF);
            end
        end
        dc_ready_i = hold_ready ? 1'b0 : (($unsigned($random(seed)) % 4) != 0);
    end

    ////////////////////////////////////////////////////////////////////////////
    // Monitor sampling at the rising edge before any register moves
    ////////////////////////////////////////////////////////////////////////////
    always @(posedge clk_i) begin
        int idx;
        int req_idx;
        if (rstn_i) begin
            assert (!(dc_req_valid_o && !dc_ready_i))
                else report_error("request while not ready");
            if (wd_idx >= 0) begin
                assert (dc_req_wdata_o == row_wdata[wd_idx]) else report_error("store data");
                wd_idx = -1;
            end
            if (stall_pend) begin
                assert (commit_stall_o) else report_error("commit_stall_o low with store out");
            end
            if (wb_valid_o) begin
                assert (!kill_phase) else report_error("writeback after kill");
                assert (load_pos < load_list.size()) else report_error("extra writeback");
                idx = load_list[load_pos];
                load_pos++;
                assert (wb_rd_o == row_rd[idx] && wb_gl_index_o == row_gl[idx])
                    else report_error("writeback rd or gl_index");
                assert (wb_xcpt_valid_o == row_xv[idx]) else report_error("load xcpt flag");
                if (row_xv[idx]) begin
                    assert (wb_xcpt_cause_o == row_cause[idx] &&
                            wb_xcpt_origin_o == row_base[idx] + row_imm[idx])
                        else report_error("load xcpt cause or origin");
                end else begin
                    assert (wb_data_o == row_data[idx]) else report_error("load data");
                end
            end
            if (commit_xcpt_valid_o) begin
                assert (stx_pos < stx_list.size()) else report_error("extra store xcpt");
                idx = stx_list[stx_pos];
                stx_pos++;
                assert (commit_xcpt_cause_o == row_cause[idx] &&
                        commit_xcpt_origin_o == row_base[idx] + row_imm[idx])
                    else report_error("store xcpt cause or origin");
            end
            if (p2_idx >= 0 && op_writes_mem(row_op[p2_idx])) stall_pend = 1'b0;
            req_idx = -1;
            if (dc_req_valid_o) begin
                req_idx = find_row(dc_req_addr_o);
                assert (req_idx >= 0) else report_error("request to unknown address");
                assert (dc_req_op_o == row_op[req_idx]) else report_error("request op");
                if (op_writes_mem(row_op[req_idx])) begin
                    assert (commit_store_i && commit_stall_o) else report_error("store gating");
                    stall_pend = 1'b1;
                    wd_idx     = req_idx;
                end
            end
            if (nack_now || kill_i) begin
                p2_idx     = -1;    // Both stages flushed
                p1_idx     = -1;
                stall_pend = 1'b0;
            end else begin
                p2_idx = p1_idx;
                p1_idx = req_idx;
            end
        end
    end

    initial begin
        seed = 32'hce95_d58c;
        {kill_i, instr_valid_i, dc_ready_i, commit_store_i} = '0;
        {dc_resp_valid_i, dc_resp_nack_i, dc_resp_ma_i, dc_resp_pf_i} = '0;
        instr_op_i = LD;
        {instr_rd_i, instr_gl_index_i} = '0;
        {instr_base_i, instr_imm_i, instr_wdata_i, dc_resp_data_i} = '0;
        {nack_now, stall_pend, hold_ready, kill_phase} = '0;
        {load_pos, stx_pos, cs_wait} = '0;
        p1_idx = -1;
        p2_idx = -1;
        wd_idx = -1;
        //      op   base                   imm      rd gl wdata  act  data  xv cause
        add_row(0,  LD,  64'h1000, 64'h8,  5'd1, 6'd1, 0, ACT_OK, 64'hA1, 0, LD_ADDR_MISALIGNED);
        add_row(1,  LW,  64'h1000, 64'h10, 5'd2, 6'd2, 0, ACT_NACK, 64'hB2, 0, LD_ADDR_MISALIGNED);
        add_row(2,  LH,  64'h1000, 64'h20, 5'd3, 6'd3, 0, ACT_OK, 64'hC3, 0, LD_ADDR_MISALIGNED);
        add_row(3,  SD,  64'h2000, 64'h0,  5'd0, 6'd4, 64'h5D5D, ACT_OK, 0, 0, LD_ADDR_MISALIGNED);
        add_row(4,  LB,  64'h1000, 64'h31, 5'd5, 6'd5, 0, ACT_MA, 0, 1, LD_ADDR_MISALIGNED);
        add_row(5,  SW,  64'h2000, 64'h12, 5'd0, 6'd6, 64'h77, ACT_MA, 0, 1, ST_ADDR_MISALIGNED);
        add_row(6,  LD,  64'h3000, 64'h0,  5'd7, 6'd7, 0, ACT_PF, 0, 1, LD_PAGE_FAULT);
        add_row(7,  SH,  64'h4000, 64'h0,  5'd0, 6'd8, 64'h88, ACT_PF, 0, 1, ST_PAGE_FAULT);
        add_row(8,  LWU, 64'h0000_8000_0000_0000, 64'h10, 5'd9, 6'd9, 0, ACT_OK, 0, 1,
                LD_ACCESS_FAULT);
        add_row(9,  SB,  64'h0001_0000_0000_0000, 64'h4, 5'd0, 6'd10, 64'h9, ACT_OK, 0, 1,
                ST_ACCESS_FAULT);
        add_row(10, LHU, 64'hFFFF_FFC0_0000_0000, 64'h8, 5'd11, 6'd11, 0, ACT_OK, 64'hEE, 0,
                LD_ADDR_MISALIGNED);
        add_row(11, SD,  64'h2000, 64'h40, 5'd0, 6'd12, 64'hCAFE, ACT_NACK, 0, 0,
                LD_ADDR_MISALIGNED);
        // Page fault outranks a non-canonical address
        add_row(12, LBU, 64'h0000_4000_0000_0000, 64'h20, 5'd13, 6'd13, 0, ACT_PF, 0, 1,
                LD_PAGE_FAULT);
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (!op_writes_mem(row_op[i])) load_list.push_back(i);
            else if (row_xv[i]) stx_list.push_back(i);
        end
        @(posedge rstn_i);
        @(negedge clk_i);
        assert (empty_o && !lock_o && !wb_valid_o && !commit_stall_o &&
                !dc_req_valid_o && !commit_xcpt_valid_o)
            else report_error("outputs after reset");
        for (int i = 0; i < NUM_ROWS; i++) push_row(i);
        while (load_pos < load_list.size() || stx_pos < stx_list.size() ||
               !empty_o || commit_stall_o) @(negedge clk_i);

        // Kill with entries still queued
        hold_ready = 1'b1;
        repeat (2) @(negedge clk_i);
        for (int i = 0; i < 3; i++) push_row(i);
        kill_phase = 1'b1;
        kill_i     = 1'b1;
        @(negedge clk_i);
        kill_i     = 1'b0;
        @(negedge clk_i);
        assert (empty_o) else report_error("empty_o low after kill");
        hold_ready = 1'b0;
        repeat (20) @(negedge clk_i);
        assert (empty_o) else report_error("queue refilled after kill");
        $display("All tests passed!");
        $finish;
    end

    // Watchdog sized from the table length plus the kill sequence
    initial begin
        repeat ((NUM_ROWS + 1) * 40) @(posedge clk_i);
        $display("Timeout: the run did not finish in time");
        $display("Test failures found");
        $fatal(1, "Watchdog expired");
    end

endmodule

// ==== list.f ====
logic/mem_pkg.sv
logic/load_store_queue.sv
logic/mem_issue_ctrl.sv
logic/mem_resp_pipe.sv
logic/mem_xcpt_check.sv
logic/mem_unit.sv
testbench/tb_clock_gen.sv
testbench/tb_mem_unit.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator and run; exit status follows the simulation
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module tb_mem_unit -f list.f -o sim_mem_unit &&
./obj_dir/sim_mem_unit || exit 1
